// File: logic/alu_unit.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module alu_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue,
    input  ex_pkg::is_ex_packet_t is_ex_reg,
    input  isa_pkg::xlen_t        opa,
    input  isa_pkg::xlen_t        opb,
    output ex_pkg::fu_out_t       alu_out
);

    logic               accept;
    logic               done;
    isa_pkg::xlen_t     opa_q;
    isa_pkg::xlen_t     opb_q;
    isa_pkg::alu_func_t func_q;
    ex_pkg::tag_t       tag_q;
    isa_pkg::shamt_t    shamt;
    isa_pkg::xlen_t     result;

    assign accept = issue && (is_ex_reg.fu_type == isa_pkg::FU_ALU);

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= accept;     // One cycle per issue
        end
    end

    // Operation registers
    always_ff @(posedge clock) begin
        if (accept) begin
            opa_q  <= opa;
            opb_q  <= opb;
            func_q <= is_ex_reg.alu_func;
            tag_q  <= is_ex_reg.tag;
        end
    end

    assign shamt = opb_q[`EX_SHAMT_W-1:0];

    always_comb begin
        case (func_q)
            isa_pkg::ALU_ADD:  result = opa_q + opb_q;
            isa_pkg::ALU_SUB:  result = opa_q - opb_q;
            isa_pkg::ALU_SLT:  result = isa_pkg::xlen_t'($signed(opa_q) < $signed(opb_q));
            isa_pkg::ALU_SLTU: result = isa_pkg::xlen_t'(opa_q < opb_q);
            isa_pkg::ALU_AND:  result = opa_q & opb_q;
            isa_pkg::ALU_OR:   result = opa_q | opb_q;
            isa_pkg::ALU_XOR:  result = opa_q ^ opb_q;
            isa_pkg::ALU_SLL:  result = opa_q << shamt;
            isa_pkg::ALU_SRL:  result = opa_q >> shamt;
            isa_pkg::ALU_SRA:  result = $signed(opa_q) >>> shamt;    // Sign fill
            default:           result = '0;
        endcase
    end

    assign alu_out.done        = done;
    assign alu_out.value       = result;
    assign alu_out.take_branch = 1'b0;
    assign alu_out.tag         = tag_q;

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module branch_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue,
    input  ex_pkg::is_ex_packet_t is_ex_reg,
    input  isa_pkg::xlen_t        opa,
    input  isa_pkg::xlen_t        opb,
    output ex_pkg::fu_out_t       br_out
);

    logic              accept;
    logic              done;
    isa_pkg::xlen_t    opa_q;
    isa_pkg::xlen_t    opb_q;
    isa_pkg::xlen_t    rs1_q;
    isa_pkg::br_cond_t cond_q;
    logic              cond_branch_q;
    logic              uncond_branch_q;
    ex_pkg::tag_t      tag_q;
    logic              cond_true;

    assign accept = issue && (is_ex_reg.fu_type == isa_pkg::FU_BRANCH);

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            opa_q           <= opa;
            opb_q           <= opb;
            rs1_q           <= is_ex_reg.rs1_value;
            cond_q          <= isa_pkg::br_cond_t'(is_ex_reg.inst[14:12]);  // funct3
            cond_branch_q   <= is_ex_reg.cond_branch;
            uncond_branch_q <= is_ex_reg.uncond_branch;
            tag_q           <= is_ex_reg.tag;   // rs2 rides in here
        end
    end

    //////////////////////////////////////////////////
    // Condition evaluation
    //////////////////////////////////////////////////

    always_comb begin
        case (cond_q)
            isa_pkg::BR_EQ:  cond_true = rs1_q == tag_q.rs2_value;
            isa_pkg::BR_NE:  cond_true = rs1_q != tag_q.rs2_value;
            isa_pkg::BR_LT:  cond_true = $signed(rs1_q) < $signed(tag_q.rs2_value);
            isa_pkg::BR_GE:  cond_true = $signed(rs1_q) >= $signed(tag_q.rs2_value);
            isa_pkg::BR_LTU: cond_true = rs1_q < tag_q.rs2_value;
            isa_pkg::BR_GEU: cond_true = rs1_q >= tag_q.rs2_value;
            default:         cond_true = 1'b0;  // Undefined funct3 never taken
        endcase
    end

    assign br_out.done        = done;
    assign br_out.value       = opa_q + opb_q;  // Target address
    assign br_out.take_branch = uncond_branch_q || (cond_branch_q && cond_true);
    assign br_out.tag         = tag_q;

endmodule

// File: logic/complete_ctrl.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module complete_ctrl (
    input  logic                  clock,
    input  logic                  reset,
    input  ex_pkg::fu_out_t       alu_out,
    input  ex_pkg::fu_out_t       br_out,
    output ex_pkg::ex_co_packet_t ex_packet,
    output logic                  free_alu,
    output logic                  free_branch
);

    logic            alu_pend;
    logic            br_pend;
    ex_pkg::fu_out_t alu_slot;
    ex_pkg::fu_out_t br_slot;
    ex_pkg::fu_out_t head;     // Slot retiring this cycle

    //////////////////////////////////////////////////
    // Pending result slots
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alu_out.done) begin
            alu_slot <= alu_out;
        end
        if (br_out.done) begin
            br_slot <= br_out;
        end
    end

    // ALU has priority
    assign head = alu_pend ? alu_slot : br_slot;

    //////////////////////////////////////////////////
    // Retirement
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_pend        <= 1'b0;
            br_pend         <= 1'b0;
            ex_packet.valid <= 1'b0;
            free_alu        <= 1'b0;
            free_branch     <= 1'b0;
        end else begin
            ex_packet.valid       <= alu_pend || br_pend;
            ex_packet.result      <= head.value;
            ex_packet.take_branch <= head.take_branch;
            ex_packet.tag         <= head.tag;
            free_alu              <= alu_pend;
            free_branch           <= br_pend && !alu_pend;

            if (alu_pend) begin
                alu_pend <= 1'b0;
            end else if (br_pend) begin
                br_pend <= 1'b0;
            end

            // A new result wins over the clear above
            if (alu_out.done) begin
                alu_pend <= 1'b1;
            end
            if (br_out.done) begin
                br_pend <= 1'b1;
            end
        end
    end

endmodule

// File: logic/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

//////////////////////////////////////////////////
// Execute stage widths
//////////////////////////////////////////////////

// Data path
`define EX_XLEN 32

// Destination register index into the register file
`define EX_REG_IDX_W 5

// Reorder buffer slot index
`define EX_ROB_IDX_W 5

// Shift amount taken from the low bits of operand B
`define EX_SHAMT_W 5

`endif

// File: logic/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

    typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`EX_ROB_IDX_W-1:0] rob_idx_t;

    // Fields carried through the stage untouched
    typedef struct packed {
        reg_idx_t      dest_reg_idx;
        rob_idx_t      rob_index;
        isa_pkg::xlen_t npc;
        isa_pkg::xlen_t rs2_value;    // Store data and branch compare
        logic          halt;
    } tag_t;

    typedef struct packed {
        logic                valid;
        isa_pkg::inst_t      inst;
        isa_pkg::xlen_t      pc;
        isa_pkg::xlen_t      rs1_value;
        isa_pkg::opa_sel_t   opa_select;
        isa_pkg::opb_sel_t   opb_select;
        isa_pkg::alu_func_t  alu_func;
        isa_pkg::fu_type_t   fu_type;
        logic                cond_branch;
        logic                uncond_branch;
        tag_t                tag;
    } is_ex_packet_t;

    // One functional unit result
    typedef struct packed {
        logic           done;
        isa_pkg::xlen_t value;
        logic           take_branch;
        tag_t           tag;
    } fu_out_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::xlen_t result;
        logic           take_branch;
        tag_t           tag;
    } ex_co_packet_t;

endpackage

// File: logic/isa_pkg.sv
`include "ex_config.svh"

package isa_pkg;

    typedef logic [`EX_XLEN-1:0]    xlen_t;
    typedef logic [31:0]            inst_t;     // RV32 encodings are always 32 bits
    typedef logic [`EX_SHAMT_W-1:0] shamt_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_func_t;

    // Operand A source
    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_NPC,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_t;

    // Operand B source
    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_sel_t;

    typedef enum logic {
        FU_ALU,
        FU_BRANCH
    } fu_type_t;

    // Branch funct3 codes with 010 and 011 unused
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_t;

endpackage

// File: logic/operand_select.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module operand_select (
    input  ex_pkg::is_ex_packet_t is_ex_reg,
    output isa_pkg::xlen_t        opa,
    output isa_pkg::xlen_t        opb
);

    isa_pkg::inst_t inst;
    isa_pkg::xlen_t i_imm;
    isa_pkg::xlen_t s_imm;
    isa_pkg::xlen_t b_imm;
    isa_pkg::xlen_t u_imm;
    isa_pkg::xlen_t j_imm;

    assign inst = is_ex_reg.inst;

    //////////////////////////////////////////////////
    // Immediate extraction
    //////////////////////////////////////////////////

    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};    // Upper bits over zeros
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Operand A
    always_comb begin
        case (is_ex_reg.opa_select)
            isa_pkg::OPA_IS_RS1: opa = is_ex_reg.rs1_value;
            isa_pkg::OPA_IS_NPC: opa = is_ex_reg.tag.npc;
            isa_pkg::OPA_IS_PC:  opa = is_ex_reg.pc;
            default:             opa = '0;      // OPA_IS_ZERO
        endcase
    end

    // Operand B
    always_comb begin
        case (is_ex_reg.opb_select)
            isa_pkg::OPB_IS_RS2:   opb = is_ex_reg.tag.rs2_value;
            isa_pkg::OPB_IS_I_IMM: opb = i_imm;
            isa_pkg::OPB_IS_S_IMM: opb = s_imm;
            isa_pkg::OPB_IS_B_IMM: opb = b_imm;
            isa_pkg::OPB_IS_U_IMM: opb = u_imm;
            isa_pkg::OPB_IS_J_IMM: opb = j_imm;
            default:               opb = '0;    // Unused select codes
        endcase
    end

endmodule

// File: logic/stage_ex.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module stage_ex (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue,
    input  ex_pkg::is_ex_packet_t is_ex_reg,
    output ex_pkg::ex_co_packet_t ex_packet,
    output logic                  free_alu,
    output logic                  free_branch
);

    isa_pkg::xlen_t  opa;
    isa_pkg::xlen_t  opb;
    ex_pkg::fu_out_t alu_out;
    ex_pkg::fu_out_t br_out;

    operand_select u_operand_select (
        .is_ex_reg (is_ex_reg),
        .opa       (opa),
        .opb       (opb)
    );

    // Functional units
    alu_unit u_alu_unit (
        .clock     (clock),
        .reset     (reset),
        .issue     (issue),
        .is_ex_reg (is_ex_reg),
        .opa       (opa),
        .opb       (opb),
        .alu_out   (alu_out)
    );

    branch_unit u_branch_unit (
        .clock     (clock),
        .reset     (reset),
        .issue     (issue),
        .is_ex_reg (is_ex_reg),
        .opa       (opa),
        .opb       (opb),
        .br_out    (br_out)
    );

    complete_ctrl u_complete_ctrl (
        .clock       (clock),
        .reset       (reset),
        .alu_out     (alu_out),
        .br_out      (br_out),
        .ex_packet   (ex_packet),
        .free_alu    (free_alu),
        .free_branch (free_branch)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f --top-module tb_stage_ex \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_stage_ex > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0

// File: tb.f
+incdir+logic
logic/isa_pkg.sv
logic/ex_pkg.sv
logic/operand_select.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/complete_ctrl.sv
logic/stage_ex.sv
tb/tb_stage_ex.sv

// File: tb/tb_stage_ex.sv
`timescale 1ns/1ns

module tb_stage_ex;

    localparam int NUM_TXN        = 400;
    localparam int TIMEOUT_CYCLES = 8 * NUM_TXN + 100;

    logic                  clock;
    logic                  reset;
    logic                  issue;
    ex_pkg::is_ex_packet_t is_ex_reg;
    ex_pkg::ex_co_packet_t ex_packet;
    logic                  free_alu;
    logic                  free_branch;

    logic [31:0] lfsr = 32'h4563_5721;
    int          cycle = 0;
    int          issued = 0;
    int          mismatch_errors = 0;
    int          completion_errors = 0;

    // Expected completions per unit and the cycle each is due
    ex_pkg::ex_co_packet_t alu_q[$];
    ex_pkg::ex_co_packet_t br_q[$];
    int                    alu_due[$];
    int                    br_due[$];

    stage_ex u_stage_ex (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .is_ex_reg   (is_ex_reg),
        .ex_packet   (ex_packet),
        .free_alu    (free_alu),
        .free_branch (free_branch)
    );

    always #2 clock = ~clock;

    //////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic isa_pkg::xlen_t imm_value(input isa_pkg::inst_t inst,
                                                 input isa_pkg::opb_sel_t sel);
        logic [31:0] sx;
        sx = {32{inst[31]}};
        case (sel)
            isa_pkg::OPB_IS_I_IMM: return {sx[31:12], inst[31:20]};
            isa_pkg::OPB_IS_S_IMM: return {sx[31:12], inst[31:25], inst[11:7]};
            isa_pkg::OPB_IS_B_IMM:
                return {sx[31:13], inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            isa_pkg::OPB_IS_U_IMM: return {inst[31:12], 12'h000};
            isa_pkg::OPB_IS_J_IMM:
                return {sx[31:21], inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:               return '0;
        endcase
    endfunction

    function automatic isa_pkg::xlen_t model_opa(input ex_pkg::is_ex_packet_t pkt);
        case (pkt.opa_select)
            isa_pkg::OPA_IS_RS1: return pkt.rs1_value;
            isa_pkg::OPA_IS_NPC: return pkt.tag.npc;
            isa_pkg::OPA_IS_PC:  return pkt.pc;
            default:             return '0;
        endcase
    endfunction

    function automatic isa_pkg::xlen_t model_opb(input ex_pkg::is_ex_packet_t pkt);
        if (pkt.opb_select == isa_pkg::OPB_IS_RS2) begin
            return pkt.tag.rs2_value;
        end
        return imm_value(pkt.inst, pkt.opb_select);
    endfunction

    function automatic isa_pkg::xlen_t alu_model(input isa_pkg::alu_func_t func,
                                                 input isa_pkg::xlen_t a,
                                                 input isa_pkg::xlen_t b);
        case (func)
            isa_pkg::ALU_ADD:  return a + b;
            isa_pkg::ALU_SUB:  return a - b;
            isa_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            isa_pkg::ALU_SLTU: return {31'b0, a < b};
            isa_pkg::ALU_AND:  return a & b;
            isa_pkg::ALU_OR:   return a | b;
            isa_pkg::ALU_XOR:  return a ^ b;
            isa_pkg::ALU_SLL:  return a << b[4:0];
            isa_pkg::ALU_SRL:  return a >> b[4:0];
            isa_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            default:           return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input ex_pkg::is_ex_packet_t pkt);
        logic        hit;
        logic [31:0] rs1;
        logic [31:0] rs2;
        rs1 = pkt.rs1_value;
        rs2 = pkt.tag.rs2_value;
        case (pkt.inst[14:12])
            3'b000:  hit = rs1 == rs2;
            3'b001:  hit = rs1 != rs2;
            3'b100:  hit = $signed(rs1) < $signed(rs2);
            3'b101:  hit = $signed(rs1) >= $signed(rs2);
            3'b110:  hit = rs1 < rs2;
            3'b111:  hit = rs1 >= rs2;
            default: hit = 1'b0;    // 010 and 011 are not branches
        endcase
        return pkt.uncond_branch || (pkt.cond_branch && hit);
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic send_packet(input logic to_branch);
        ex_pkg::is_ex_packet_t pkt;
        ex_pkg::ex_co_packet_t exp;
        pkt                  = '0;
        pkt.valid            = 1'b1;
        pkt.inst             = rand_bits(32);
        pkt.pc               = rand_bits(30) << 2;
        pkt.rs1_value        = rand_bits(32);
        pkt.tag.npc          = pkt.pc + 32'd4;
        // Equal to rs1 now and then
        pkt.tag.rs2_value    = (rand_bits(2) == 0) ? pkt.rs1_value : rand_bits(32);
        pkt.tag.dest_reg_idx = 5'(rand_bits(5));
        pkt.tag.rob_index    = 5'(rand_bits(5));
        pkt.tag.halt         = 1'(rand_bits(1));
        pkt.opa_select       = isa_pkg::opa_sel_t'(2'(rand_bits(2)));
        pkt.opb_select       = isa_pkg::opb_sel_t'(3'(rand_bits(3) % 6));
        pkt.alu_func         = isa_pkg::ALU_ADD;
        if (to_branch) begin
            pkt.fu_type       = isa_pkg::FU_BRANCH;
            pkt.cond_branch   = 1'(rand_bits(1));
            pkt.uncond_branch = 1'(rand_bits(1));
        end else begin
            pkt.fu_type = isa_pkg::FU_ALU;
            if (rand_bits(1) != 0) begin
                // Register operands with any function
                pkt.opa_select = isa_pkg::OPA_IS_RS1;
                pkt.opb_select = isa_pkg::OPB_IS_RS2;
                pkt.alu_func   = isa_pkg::alu_func_t'(4'(rand_bits(4) % 10));
            end
        end

        exp       = '0;
        exp.valid = 1'b1;
        exp.tag   = pkt.tag;
        if (to_branch) begin
            exp.result      = model_opa(pkt) + model_opb(pkt);
            exp.take_branch = branch_taken(pkt);
            br_q.push_back(exp);
            br_due.push_back(cycle + 3);
        end else begin
            exp.result = alu_model(pkt.alu_func, model_opa(pkt), model_opb(pkt));
            alu_q.push_back(exp);
            alu_due.push_back(cycle + 3);   // Sampled next edge and retired two later
        end

        issue     <= 1'b1;
        is_ex_reg <= pkt;
        issued++;
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        mismatch_errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic check_completion(input ex_pkg::ex_co_packet_t exp,
                                    input logic is_alu,
                                    input string unit);
        assert (ex_packet.valid) else begin
            completion_errors++;
            $display("%s result did not complete at %0t ns as expected", unit, $time);
        end
        if (ex_packet.valid) begin
            assert (ex_packet.result == exp.result) else
                report_mismatch($sformatf("%s result got %h expected %h",
                                          unit, ex_packet.result, exp.result));
            assert (ex_packet.take_branch == exp.take_branch) else
                report_mismatch($sformatf("%s take_branch got %b expected %b",
                                          unit, ex_packet.take_branch, exp.take_branch));
            assert (ex_packet.tag == exp.tag) else
                report_mismatch($sformatf("%s tag got %h expected %h",
                                          unit, ex_packet.tag, exp.tag));
            assert (free_alu == is_alu && free_branch == !is_alu) else
                report_mismatch($sformatf("%s free lines got alu %b branch %b",
                                          unit, free_alu, free_branch));
        end
    endtask

    task automatic check_outputs();
        logic                  exp_alu;
        logic                  exp_br;
        ex_pkg::ex_co_packet_t exp;
        exp_alu = (alu_q.size() > 0) && (alu_due[0] == cycle);
        exp_br  = (br_q.size() > 0) && (br_due[0] <= cycle) && !exp_alu;   // ALU goes first
        if (exp_alu) begin
            exp = alu_q.pop_front();
            void'(alu_due.pop_front());
            check_completion(exp, 1'b1, "ALU");
        end else if (exp_br) begin
            exp = br_q.pop_front();
            void'(br_due.pop_front());
            check_completion(exp, 1'b0, "Branch");
        end else begin
            assert (!ex_packet.valid && !free_alu && !free_branch) else begin
                completion_errors++;
                $display("Completion or free pulse at %0t ns with no result due", $time);
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            check_outputs();
        end
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, %0d mismatches, %0d completion errors",
                 cycle, mismatch_errors, completion_errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic pick;
        clock     = 1'b0;
        reset     = 1'b1;
        issue     = 1'b0;
        is_ex_reg = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        while (issued < NUM_TXN || alu_q.size() > 0 || br_q.size() > 0) begin
            @(posedge clock);
            cycle = cycle + 1;
            issue           <= 1'b0;
            is_ex_reg.valid <= 1'b0;
            // Only to a unit with nothing in flight
            if (issued < NUM_TXN && rand_bits(2) != 0) begin
                pick = 1'(rand_bits(1));
                if (br_q.size() == 0 && (pick || alu_q.size() != 0)) begin
                    send_packet(1'b1);
                end else if (alu_q.size() == 0) begin
                    send_packet(1'b0);
                end
            end
        end
        repeat (4) @(posedge clock);    // Catch stray completions

        $display("Errors: %0d mismatches, %0d completion errors over %0d issues",
                 mismatch_errors, completion_errors, issued);
        if (mismatch_errors == 0 && completion_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
